//--- video_top.f
logic/video_pkg.sv
logic/video_timing_if.sv
logic/video_cfg_if.sv
logic/video_regs.sv
logic/video_sync.sv
logic/video_gfx.sv
logic/video_sprite.sv
logic/video_mix.sv
logic/video_top.sv
verif/video_checker.sv
verif/video_props.sv
verif/video_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= video_tb
FLIST ?= video_top.f
BUILD ?= obj_dir
VFLAGS ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(BUILD)

//--- verif/video_tb.sv
`timescale 1ns/1ps
`default_nettype none

module video_tb;

	localparam int period = 40;
	localparam int rows = 4;

	logic        clk;
	logic        rst_n;
	logic [3:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  pwdata;
	wire  [7:0]  prdata;
	wire         pready;
	wire         pslverr;
	wire  [15:0] mem_addr;
	logic [7:0]  mem_rdata;
	wire  [7:0]  vplex;
	wire         hsync;
	wire         vsync;
	wire         int_start;

	video_pkg::video_cfg_t exp_cfg;
	video_pkg::video_cfg_t table_cfg [rows];
	logic [7:0] mid_border [rows];
	logic       mid_en [rows];
	logic       arm;
	logic       hung;
	int         frames_done;
	int         timeouts;
	logic [7:0] rd;
	logic       err;
	int         n;

	video_top dut (.*);

	video_checker chk (.*);

	// address is registered in the DUT, so data here lands one cycle after it
	assign mem_rdata = mem_addr[15:8] ^ 8'(mem_addr[7:0] * 3);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	function automatic video_pkg::video_cfg_t make_row(
		logic [7:0] border, logic [7:0] vconf, logic [7:0] gx, logic [7:0] gy,
		logic [3:0] pal, logic [7:0] int_line,
		logic [7:0] x0, logic [7:0] y0, logic [7:0] c0, logic e0,
		logic [7:0] x1, logic [7:0] y1, logic [7:0] c1, logic e1);
		video_pkg::video_cfg_t c;
		c = '0;
		c.border = border;
		c.vconf = vconf;
		c.gx_offs = gx;
		c.gy_offs = gy;
		c.palsel = pal;
		c.int_line = int_line;
		c.spr[0] = '{x: x0, y: y0, colour: c0, enable: e0};
		c.spr[1] = '{x: x1, y: y1, colour: c1, enable: e1};
		return c;
	endfunction

	// register map view of one configuration
	function automatic logic [7:0] reg_value(video_pkg::video_cfg_t c, int idx);
		video_pkg::spr_t s;
		s = c.spr[idx >= 12];
		case (idx)
			0: return c.border;
			1: return c.vconf;
			2: return c.gx_offs;
			3: return c.gy_offs;
			4: return {4'd0, c.palsel};
			5: return c.int_line;
			default: ;
		endcase
		case (idx % 4)
			0: return s.x;
			1: return s.y;
			2: return s.colour;
			default: return {7'd0, s.enable};
		endcase
	endfunction

	task automatic apb_access(input logic [3:0] addr, input logic wr, input logic [7:0] data,
		output logic [7:0] rdata, output logic slverr);
		@(posedge clk);
		paddr <= addr;
		pwrite <= wr;
		pwdata <= data;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		// response is stable mid access phase
		@(negedge clk);
		rdata = prdata;
		slverr = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_vsync_rise();
		int cnt;
		logic prev;
		cnt = 0;
		prev = 1'b1;
		while (!hung && !(vsync && !prev)) begin
			prev = vsync;
			@(negedge clk);
			cnt++;
			if (cnt > 3000) begin
				$display("timeout: no rising edge on vsync");
				timeouts++;
				hung = 1'b1;
			end
		end
		@(posedge clk);
	endtask

	task automatic wait_frame_done(input int start);
		int cnt;
		cnt = 0;
		while (!hung && frames_done == start) begin
			@(posedge clk);
			cnt++;
			if (cnt > 2500) begin
				$display("timeout: checker never finished a frame");
				timeouts++;
				hung = 1'b1;
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		arm = 1'b0;
		hung = 1'b0;
		timeouts = 0;
		exp_cfg = '0;
		// border vconf gx gy pal int | spr0 x y col en | spr1 x y col en
		table_cfg[0] = make_row(8'h11, 8'h00, 8'h05, 8'hf3, 4'h0, 8'd3,
			8'd0, 8'd0, 8'h00, 1'b0, 8'd0, 8'd0, 8'h00, 1'b0);
		table_cfg[1] = make_row(8'h22, 8'h01, 8'h13, 8'h02, 4'ha, 8'd10,
			8'd4, 8'd4, 8'h81, 1'b1, 8'd8, 8'd6, 8'h92, 1'b1);
		table_cfg[2] = make_row(8'h33, 8'h02, 8'h00, 8'h00, 4'h0, 8'd0,
			8'd20, 8'd2, 8'h44, 1'b1, 8'd26, 8'd10, 8'h55, 1'b0);
		table_cfg[3] = make_row(8'h5a, 8'h00, 8'hfe, 8'hfc, 4'h3, 8'd15,
			8'd0, 8'd0, 8'h00, 1'b0, 8'd28, 8'd12, 8'h66, 1'b1);
		mid_en = '{1'b0, 1'b0, 1'b0, 1'b1};
		mid_border = '{8'h00, 8'h00, 8'h00, 8'hc3};
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		for (int r = 0; r < rows && !hung; r++) begin
			for (int idx = 0; idx < 16; idx++) begin
				if (idx != 6 && idx != 7) begin
					apb_access(4'(idx), 1'b1, reg_value(table_cfg[r], idx), rd, err);
					chk.check_value("pslverr", {7'd0, err}, 8'h00);
				end
			end
			// unmapped indices answer with an error and store nothing
			apb_access(4'd6, 1'b1, 8'haa, rd, err);
			chk.check_value("pslverr", {7'd0, err}, 8'h01);
			apb_access(4'd7, 1'b1, 8'h55, rd, err);
			chk.check_value("pslverr", {7'd0, err}, 8'h01);
			for (int idx = 0; idx < 16; idx++) begin
				if (idx != 6 && idx != 7) begin
					apb_access(4'(idx), 1'b0, 8'h00, rd, err);
					chk.check_value("prdata", rd, reg_value(table_cfg[r], idx));
				end
			end

			wait_vsync_rise();
			wait_vsync_rise();
			exp_cfg = table_cfg[r];
			n = frames_done;
			arm = 1'b1;
			if (mid_en[r] && !hung) begin
				// border change lands mid-frame and shows only in the next one
				repeat (300) @(posedge clk);
				apb_access(video_pkg::reg_border, 1'b1, mid_border[r], rd, err);
				wait_frame_done(n);
				exp_cfg.border = mid_border[r];
				n = frames_done;
			end
			wait_frame_done(n);
			arm = 1'b0;
		end

		$display("errors %0d, timeouts %0d", chk.errors, timeouts);
		if (chk.errors == 0 && timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/video_props.sv
`timescale 1ns/1ps
`default_nettype none

module video_props #(
	parameter int HSYNC_LEN = video_pkg::hsync_len_def
) (
	input wire       clk,
	input wire       rst_n,
	input wire [3:0] paddr,
	input wire       psel,
	input wire       penable,
	input wire       pready,
	input wire       pslverr,
	input wire       hsync,
	input wire       int_start
);

	int hs_len;

	// length of the current hsync pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hs_len <= 0;
		end else begin
			hs_len <= hsync ? hs_len + 1 : 0;
		end
	end

	a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready)
		else $error("pready dropped low");

	a_hsync_len: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(hsync) |-> hs_len == HSYNC_LEN)
		else $error("hsync pulse has the wrong width");

	a_int_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		int_start |=> !int_start)
		else $error("int_start longer than one cycle");

	// only the two unmapped indices may answer with an error
	a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> psel && penable && (paddr == 4'd6 || paddr == 4'd7))
		else $error("pslverr outside an access phase to an unmapped index");

endmodule

bind video_top video_props #(.HSYNC_LEN(HSYNC_LEN)) props (.*);

`default_nettype wire

//--- verif/video_checker.sv
`timescale 1ns/1ps
`default_nettype none

module video_checker (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire  [7:0]            vplex,
	input  wire                   hsync,
	input  wire                   vsync,
	input  wire                   int_start,
	input  video_pkg::video_cfg_t exp_cfg,
	input  wire                   arm,
	output int                    frames_done
);

	localparam int h_act = video_pkg::h_active_def;
	localparam int h_tot = video_pkg::h_total_def;
	localparam int v_act = video_pkg::v_active_def;
	localparam int v_tot = video_pkg::v_total_def;
	localparam int hs_len = video_pkg::hsync_len_def;

	int   errors;
	int   h;
	int   v;
	logic synced;
	logic prev_vs;
	logic running;

	function automatic logic covers(video_pkg::spr_t s, int hp, int vp);
		return s.enable && hp >= s.x && hp < s.x + 8 && vp >= s.y && vp < s.y + 8;
	endfunction

	function automatic logic [7:0] exp_pix(video_pkg::video_cfg_t c, int hp, int vp);
		logic [7:0]  row;
		logic [7:0]  col;
		logic [7:0]  mem_byte;
		logic [15:0] addr;
		if (hp >= h_act || vp >= v_act) return c.border;
		if (covers(c.spr[0], hp, vp)) return c.spr[0].colour;
		if (covers(c.spr[1], hp, vp)) return c.spr[1].colour;
		if (c.vconf.gfx_off) return c.border;
		row = 8'(vp + int'(c.gy_offs));
		col = 8'(hp + int'(c.gx_offs));
		addr = c.vconf.mode_4bpp ? 16'(row * 256 + col / 2) : 16'(row * 256 + col);
		mem_byte = addr[15:8] ^ 8'(addr[7:0] * 3);
		if (!c.vconf.mode_4bpp) return mem_byte;
		// even column takes the high nibble
		return {c.palsel, col[0] ? mem_byte[3:0] : mem_byte[7:4]};
	endfunction

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_at(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s at h=%0d v=%0d: got %h expected %h", name, h, v, got, exp);
		end
	endtask

	initial begin
		errors = 0;
		frames_done = 0;
	end

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin
		if (!rst_n) begin
			synced = 1'b0;
			prev_vs = 1'b0;
			running = 1'b0;
			h = 0;
			v = 0;
		end else begin
			// first slot of the vsync line resyncs the position
			if (vsync && !prev_vs) begin
				h = 0;
				v = v_act + 1;
				synced = 1'b1;
			end else if (synced) begin
				if (h == h_tot - 1) begin
					h = 0;
					v = (v == v_tot - 1) ? 0 : v + 1;
				end else begin
					h = h + 1;
				end
			end
			prev_vs = vsync;
			if (synced && arm && !running && h == 0 && v == 0) begin
				running = 1'b1;
			end
			if (running) begin
				check_at("vplex", vplex, exp_pix(exp_cfg, h, v));
				check_at("hsync", {7'd0, hsync}, {7'd0, h >= h_act + 4 && h < h_act + 4 + hs_len});
				check_at("vsync", {7'd0, vsync}, {7'd0, v == v_act + 1});
				check_at("int_start", {7'd0, int_start},
					{7'd0, h == 0 && v == int'(exp_cfg.int_line)});
				if (h == h_tot - 1 && v == v_tot - 1) begin
					running = 1'b0;
					frames_done = frames_done + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top #(
	parameter int H_ACTIVE = video_pkg::h_active_def,
	parameter int H_TOTAL = video_pkg::h_total_def,
	parameter int V_ACTIVE = video_pkg::v_active_def,
	parameter int V_TOTAL = video_pkg::v_total_def,
	parameter int HSYNC_LEN = video_pkg::hsync_len_def
) (
	input  wire         clk,
	input  wire         rst_n,
	// APB slave
	input  wire  [3:0]  paddr,
	input  wire         psel,
	input  wire         penable,
	input  wire         pwrite,
	input  wire  [7:0]  pwdata,
	output logic [7:0]  prdata,
	output logic        pready,
	output logic        pslverr,
	// video memory, one clock read latency
	output logic [15:0] mem_addr,
	input  wire  [7:0]  mem_rdata,
	// video out
	output logic [7:0]  vplex,
	output logic        hsync,
	output logic        vsync,
	output logic        int_start
);

	logic [7:0] gfx_pix;
	logic [7:0] spr_pix;
	logic       spr_hit;
	logic       int_raw;

	video_timing_if timing ();
	video_cfg_if    cfg ();

	video_regs video_regs (.*);

	video_sync #(
		.H_ACTIVE  (H_ACTIVE),
		.H_TOTAL   (H_TOTAL),
		.V_ACTIVE  (V_ACTIVE),
		.V_TOTAL   (V_TOTAL),
		.HSYNC_LEN (HSYNC_LEN)
	) video_sync (
		.int_start (int_raw),
		.*
	);

	// the two layers run side by side on the same raster state
	video_gfx video_gfx (.*);

	video_sprite video_sprite (.*);

	video_mix #(
		.H_ACTIVE (H_ACTIVE),
		.V_ACTIVE (V_ACTIVE)
	) video_mix (.*);

endmodule

`default_nettype wire

//--- logic/video_mix.sv
`timescale 1ns/1ps
`default_nettype none

module video_mix #(
	parameter int H_ACTIVE = video_pkg::h_active_def,
	parameter int V_ACTIVE = video_pkg::v_active_def
) (
	input  wire        clk,
	input  wire        rst_n,
	video_timing_if.sink timing,
	video_cfg_if.sink  cfg,
	input  wire  [7:0] gfx_pix,
	input  wire  [7:0] spr_pix,
	input  wire        spr_hit,
	input  wire        int_raw,
	output logic [7:0] vplex,
	output logic       hsync,
	output logic       vsync,
	output logic       int_start
);

	logic       win;
	logic [1:0] win_sr;
	logic [7:0] border_d1;
	logic [7:0] border_d2;
	logic       gfx_off_d1;
	logic       gfx_off_d2;
	logic [2:0] hs_sr;
	logic [2:0] vs_sr;
	logic [2:0] int_sr;
	logic [7:0] pix_sel;

	// window decoded locally from the raster counters
	assign win = (int'(timing.hcnt) < H_ACTIVE) && (int'(timing.vcnt) < V_ACTIVE);

	always_ff @(posedge clk) begin
		border_d1 <= cfg.cfg.border;
		border_d2 <= border_d1;
		gfx_off_d1 <= cfg.cfg.vconf.gfx_off;
		gfx_off_d2 <= gfx_off_d1;
	end

	always_comb begin
		if (!win_sr[1]) begin
			pix_sel = border_d2;
		end else if (spr_hit) begin
			pix_sel = spr_pix;
		end else if (gfx_off_d2) begin
			pix_sel = border_d2;
		end else begin
			pix_sel = gfx_pix;
		end
	end

	// output stage, syncs ride a 3-deep shift to stay with the pixels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_sr <= '0;
			hs_sr <= '0;
			vs_sr <= '0;
			int_sr <= '0;
			vplex <= '0;
		end else begin
			win_sr <= {win_sr[0], win};
			hs_sr <= {hs_sr[1:0], timing.hsync};
			vs_sr <= {vs_sr[1:0], timing.vsync};
			int_sr <= {int_sr[1:0], int_raw};
			vplex <= pix_sel;
		end
	end

	assign hsync = hs_sr[2];
	assign vsync = vs_sr[2];
	assign int_start = int_sr[2];

endmodule

`default_nettype wire

//--- logic/video_sprite.sv
`timescale 1ns/1ps
`default_nettype none

module video_sprite (
	input  wire        clk,
	input  wire        rst_n,
	video_timing_if.sink timing,
	video_cfg_if.sink  cfg,
	output logic [7:0] spr_pix,
	output logic       spr_hit
);

	logic       hit0;
	logic       hit1;
	logic [7:0] col0;
	logic [7:0] col1;

	// 8x8 box test, no wrap at the screen edge
	function automatic logic covers(video_pkg::spr_t s, logic [7:0] h, logic [7:0] v);
		logic in_x;
		logic in_y;
		in_x = ({1'b0, h} >= {1'b0, s.x}) && ({1'b0, h} < {1'b0, s.x} + 9'd8);
		in_y = ({1'b0, v} >= {1'b0, s.y}) && ({1'b0, v} < {1'b0, s.y} + 9'd8);
		return s.enable && in_x && in_y;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hit0 <= 1'b0;
			hit1 <= 1'b0;
			spr_hit <= 1'b0;
		end else begin
			hit0 <= timing.hvpix && covers(cfg.cfg.spr[0], timing.hcnt, timing.vcnt);
			hit1 <= timing.hvpix && covers(cfg.cfg.spr[1], timing.hcnt, timing.vcnt);
			spr_hit <= hit0 || hit1;
		end
	end

	// sprite 0 has priority
	always_ff @(posedge clk) begin
		col0 <= cfg.cfg.spr[0].colour;
		col1 <= cfg.cfg.spr[1].colour;
		spr_pix <= hit0 ? col0 : col1;
	end

endmodule

`default_nettype wire

//--- logic/video_gfx.sv
`timescale 1ns/1ps
`default_nettype none

module video_gfx (
	input  wire         clk,
	input  wire         rst_n,
	video_timing_if.sink timing,
	video_cfg_if.sink   cfg,
	output logic [15:0] mem_addr,
	input  wire  [7:0]  mem_rdata,
	output logic [7:0]  gfx_pix
);

	logic [7:0] row;
	logic [7:0] col;
	logic       mode_q;
	logic       nib_lo;
	logic [3:0] pal_q;
	video_pkg::video_byte_u rd_byte;

	// scrolled position, wraps at 256
	assign row = timing.vcnt + cfg.cfg.gy_offs;
	assign col = timing.hcnt + cfg.cfg.gx_offs;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q <= 1'b0;
		end else begin
			mode_q <= cfg.cfg.vconf.mode_4bpp;
		end
	end

	// stage 1: address out, pixel select kept for the decode
	always_ff @(posedge clk) begin
		if (cfg.cfg.vconf.mode_4bpp) begin
			mem_addr <= {row, 1'b0, col[7:1]};
		end else begin
			mem_addr <= {row, col};
		end
		nib_lo <= col[0];
		pal_q <= cfg.cfg.palsel;
	end

	assign rd_byte = mem_rdata;

	// stage 2: decode the returned byte
	always_ff @(posedge clk) begin
		if (!mode_q) begin
			gfx_pix <= rd_byte.index8;
		end else if (nib_lo) begin
			gfx_pix <= {pal_q, rd_byte.nib.lo};
		end else begin
			gfx_pix <= {pal_q, rd_byte.nib.hi};
		end
	end

endmodule

`default_nettype wire

//--- logic/video_sync.sv
`timescale 1ns/1ps
`default_nettype none

module video_sync #(
	parameter int H_ACTIVE = video_pkg::h_active_def,
	parameter int H_TOTAL = video_pkg::h_total_def,
	parameter int V_ACTIVE = video_pkg::v_active_def,
	parameter int V_TOTAL = video_pkg::v_total_def,
	parameter int HSYNC_LEN = video_pkg::hsync_len_def
) (
	input  wire  clk,
	input  wire  rst_n,
	video_cfg_if.sink  cfg,
	video_timing_if.src timing,
	output logic int_start
);

	logic h_wrap;
	logic v_wrap;

	assign h_wrap = int'(timing.hcnt) == H_TOTAL - 1;
	assign v_wrap = int'(timing.vcnt) == V_TOTAL - 1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timing.hcnt <= '0;
			timing.vcnt <= '0;
		end else begin
			timing.hcnt <= h_wrap ? 8'd0 : timing.hcnt + 8'd1;
			if (h_wrap) begin
				timing.vcnt <= v_wrap ? 8'd0 : timing.vcnt + 8'd1;
			end
		end
	end

	assign timing.line_start = timing.hcnt == 8'd0;
	assign timing.frame_start = timing.line_start && (timing.vcnt == 8'd0);

	// active window
	assign timing.hvpix = (int'(timing.hcnt) < H_ACTIVE) && (int'(timing.vcnt) < V_ACTIVE);

	// raw syncs, a few clocks into the blanking
	assign timing.hsync = (int'(timing.hcnt) >= H_ACTIVE + 4) &&
		(int'(timing.hcnt) < H_ACTIVE + 4 + HSYNC_LEN);
	assign timing.vsync = int'(timing.vcnt) == V_ACTIVE + 1;

	// raw line interrupt, delayed later in the mixer
	assign int_start = timing.line_start && (timing.vcnt == cfg.cfg.int_line);

endmodule

`default_nettype wire

//--- logic/video_regs.sv
`timescale 1ns/1ps
`default_nettype none

module video_regs (
	input  wire        clk,
	input  wire        rst_n,
	input  wire  [3:0] paddr,
	input  wire        psel,
	input  wire        penable,
	input  wire        pwrite,
	input  wire  [7:0] pwdata,
	output logic [7:0] prdata,
	output logic       pready,
	output logic       pslverr,
	video_timing_if.sink timing,
	video_cfg_if.src   cfg
);

	video_pkg::video_cfg_t live;
	video_pkg::spr_t       sel_spr;
	logic access;
	logic addr_bad;
	logic spr_reg;
	logic spr_idx;
	logic wr_en;

	// indices between int_line and the sprite block are unmapped
	assign addr_bad = (paddr > video_pkg::reg_int_line) && (paddr < video_pkg::reg_spr0_base);
	assign spr_reg = paddr >= video_pkg::reg_spr0_base;
	assign spr_idx = paddr >= video_pkg::reg_spr1_base;

	assign access = psel && penable;
	assign wr_en = access && pwrite && !addr_bad;
	assign pready = 1'b1;
	assign pslverr = access && addr_bad;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			live <= '0;
		end else if (wr_en) begin
			if (spr_reg) begin
				case (paddr[1:0])
					2'd0: live.spr[spr_idx].x <= pwdata;
					2'd1: live.spr[spr_idx].y <= pwdata;
					2'd2: live.spr[spr_idx].colour <= pwdata;
					default: live.spr[spr_idx].enable <= pwdata[0];
				endcase
			end else begin
				case (paddr)
					video_pkg::reg_border: live.border <= pwdata;
					video_pkg::reg_vconf: live.vconf <= pwdata;
					video_pkg::reg_gx_offs: live.gx_offs <= pwdata;
					video_pkg::reg_gy_offs: live.gy_offs <= pwdata;
					video_pkg::reg_palsel: live.palsel <= pwdata[3:0];
					video_pkg::reg_int_line: live.int_line <= pwdata;
					default: ;
				endcase
			end
		end
	end

	// readback always shows the live set
	always_comb begin
		sel_spr = live.spr[spr_idx];
		prdata = '0;
		if (spr_reg) begin
			case (paddr[1:0])
				2'd0: prdata = sel_spr.x;
				2'd1: prdata = sel_spr.y;
				2'd2: prdata = sel_spr.colour;
				default: prdata = {7'd0, sel_spr.enable};
			endcase
		end else begin
			case (paddr)
				video_pkg::reg_border: prdata = live.border;
				video_pkg::reg_vconf: prdata = live.vconf;
				video_pkg::reg_gx_offs: prdata = live.gx_offs;
				video_pkg::reg_gy_offs: prdata = live.gy_offs;
				video_pkg::reg_palsel: prdata = {4'd0, live.palsel};
				video_pkg::reg_int_line: prdata = live.int_line;
				default: prdata = '0;
			endcase
		end
	end

	// frame shadow
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg.cfg <= '0;
		end else if (timing.frame_start) begin
			cfg.cfg <= live;
		end
	end

endmodule

`default_nettype wire

//--- logic/video_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface video_cfg_if;

	// shadow copy, stable for a whole frame
	video_pkg::video_cfg_t cfg;

	modport src (
		output cfg
	);

	modport sink (
		input cfg
	);

endinterface

`default_nettype wire

//--- logic/video_timing_if.sv
`timescale 1ns/1ps
`default_nettype none

interface video_timing_if;

	logic [7:0] hcnt;
	logic [7:0] vcnt;
	logic       hvpix;
	logic       hsync;
	logic       vsync;
	logic       frame_start;
	logic       line_start;

	modport src (
		output hcnt, vcnt, hvpix, hsync, vsync, frame_start, line_start
	);

	modport sink (
		input hcnt, vcnt, hvpix, hsync, vsync, frame_start, line_start
	);

endinterface

`default_nettype wire

//--- logic/video_pkg.sv
`default_nettype none

package video_pkg;

	// default raster geometry, in clocks and lines
	localparam int h_active_def = 32;
	localparam int h_total_def = 48;
	localparam int v_active_def = 16;
	localparam int v_total_def = 20;
	localparam int hsync_len_def = 4;

	typedef logic [3:0] reg_addr_t;

	localparam reg_addr_t reg_border = 4'd0;
	localparam reg_addr_t reg_vconf = 4'd1;
	localparam reg_addr_t reg_gx_offs = 4'd2;
	localparam reg_addr_t reg_gy_offs = 4'd3;
	localparam reg_addr_t reg_palsel = 4'd4;
	localparam reg_addr_t reg_int_line = 4'd5;
	// sprite blocks: x, y, colour, enable
	localparam reg_addr_t reg_spr0_base = 4'd8;
	localparam reg_addr_t reg_spr1_base = 4'd12;

	typedef struct packed {
		logic [5:0] rsvd;
		logic       gfx_off;
		logic       mode_4bpp;
	} vconf_t;

	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] colour;
		logic       enable;
	} spr_t;

	typedef struct packed {
		logic [7:0] border;
		vconf_t     vconf;
		logic [7:0] gx_offs;
		logic [7:0] gy_offs;
		logic [3:0] palsel;
		logic [7:0] int_line;
		spr_t [1:0] spr;
	} video_cfg_t;

	// one video memory byte: 8bpp index or two 4bpp pixels
	typedef union packed {
		logic [7:0] index8;
		struct packed {
			logic [3:0] hi;
			logic [3:0] lo;
		} nib;
	} video_byte_u;

endpackage

`default_nettype wire
